// File: sdcard_pkg.sv
// SD card model shared definitions
// State encodings, command codes, bus structs and timing constants
// for the card-side command and read-data model

`default_nettype none

package sdcard_pkg;

    // Card states during identification
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        READY = 3'd1,
        IDENT = 3'd2,
        STBY  = 3'd3,
        INA   = 3'd4
    } sd_state_t;

    typedef enum logic [1:0] {
        R1 = 2'd0,
        R3 = 2'd1,
        R7 = 2'd2
    } resp_kind_t;

    // Streamer phases
    typedef enum logic [2:0] {
        TX_IDLE   = 3'd0,
        TX_TOKEN  = 3'd1,
        TX_DATA   = 3'd2,
        TX_CRC_HI = 3'd3,
        TX_CRC_LO = 3'd4
    } tx_phase_t;

    typedef struct packed {
        logic [5:0]  idx;
        logic [31:0] arg;
    } cmd_req_t;

    typedef struct packed {
        logic [31:0] data;
        resp_kind_t  kind;
        logic        illegal;
    } resp_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;   // Final byte of the block
    } dat_t;

    localparam logic [5:0] CMD_GO_IDLE       = 6'd0;
    localparam logic [5:0] CMD_ALL_SEND_CID  = 6'd2;
    localparam logic [5:0] CMD_SEND_RCA      = 6'd3;
    localparam logic [5:0] CMD_SEND_IF_COND  = 6'd8;
    localparam logic [5:0] CMD_READ_SINGLE   = 6'd17;
    localparam logic [5:0] ACMD_SEND_OP_COND = 6'd41;
    localparam logic [5:0] CMD_APP           = 6'd55;
    localparam logic [5:0] CMD_READ_OCR      = 6'd58;

    localparam int POWERUP_CYCLES = 40;    // Busy bit clears after this
    localparam int RESP_DELAY     = 4;
    localparam int BLOCK_BYTES    = 512;
    localparam int POWERUP_W      = $clog2(POWERUP_CYCLES + 1);
    localparam int DELAY_W        = $clog2(RESP_DELAY + 1);
    localparam int BYTE_CNT_W     = $clog2(BLOCK_BYTES);

    // Card capabilities
    localparam logic        CARD_HCS        = 1'b1;
    localparam logic [3:0]  CARD_VHS        = 4'h1;
    localparam logic [23:0] CARD_VDD_WINDOW = 24'hff8000;

    localparam logic [7:0]  START_TOKEN = 8'hfe;
    localparam logic [15:0] CRC16_POLY  = 16'h1021;   // x^16 + x^12 + x^5 + 1

endpackage

`default_nettype wire

// File: sdcard_crc16.sv
// Data block CRC16
// CCITT polynomial, zero seed, advanced one byte per update strobe

`timescale 1ns/1ps
`default_nettype none

module sdcard_crc16 (
    input  wire logic        i_clk,
    input  wire logic        i_nrst,
    input  wire logic        i_clear,
    input  wire logic        i_update,
    input  wire logic [7:0]  i_byte,
    output logic      [15:0] o_crc
);

    logic [15:0] crc_q;

    // Eight serial steps, MSB first as on the DAT line
    function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        logic        fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[15] ^ b[i];
            c  = {c[14:0], 1'b0};
            if (fb) begin
                c = c ^ sdcard_pkg::CRC16_POLY;
            end
        end
        return c;
    endfunction

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc_q <= '0;
        end else if (i_clear) begin
            crc_q <= '0;
        end else if (i_update) begin
            crc_q <= crc_byte(crc_q, i_byte);
        end
    end

    assign o_crc = crc_q;

endmodule

`default_nettype wire

// File: sdcard_timer.sv
// Card timer
// Power-up counter behind the ACMD41 busy bit, and the
// response-delay countdown restarted for every command

`timescale 1ns/1ps
`default_nettype none

module sdcard_timer (
    input  wire logic i_clk,
    input  wire logic i_nrst,
    input  wire logic i_start,
    output logic      o_done,
    output logic      o_powered
);

    logic [sdcard_pkg::POWERUP_W-1:0] pwr_cnt_q;
    logic [sdcard_pkg::DELAY_W-1:0]   dly_cnt_q;

    // Saturates once power-up is over
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            pwr_cnt_q <= '0;
        end else if (!o_powered) begin
            pwr_cnt_q <= pwr_cnt_q + 1'b1;
        end
    end

    assign o_powered = (pwr_cnt_q == sdcard_pkg::POWERUP_W'(sdcard_pkg::POWERUP_CYCLES));

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            dly_cnt_q <= '0;
        end else if (i_start) begin
            dly_cnt_q <= sdcard_pkg::DELAY_W'(sdcard_pkg::RESP_DELAY);
        end else if (dly_cnt_q != '0) begin
            dly_cnt_q <= dly_cnt_q - 1'b1;
        end
    end

    // One pulse on the last count
    assign o_done = (dly_cnt_q == sdcard_pkg::DELAY_W'(1));

endmodule

`default_nettype wire

// File: sdcard_data_tx.sv
// Single-block read streamer
// Sends the start token, 512 bytes of synthetic card memory and the
// CRC16 of those bytes, one byte strobe per clock

`timescale 1ns/1ps
`default_nettype none

module sdcard_data_tx (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire logic              i_start,
    input  wire logic [31:0]       i_block,
    input  wire logic [15:0]       i_crc,
    output logic                   o_crc_clear,
    output logic                   o_crc_update,
    output logic [7:0]             o_crc_byte,
    output logic                   o_active,
    output logic                   o_dat_valid,
    output sdcard_pkg::dat_t       o_dat
);

    sdcard_pkg::tx_phase_t                phase_q;
    logic [sdcard_pkg::BYTE_CNT_W-1:0]    cnt_q;
    logic [15:0]                          addr_q;   // Only A[15:0] feeds the content rule
    logic [7:0]                           mem_byte;

    // Card memory content: A[7:0] ^ A[15:8]
    assign mem_byte = addr_q[7:0] ^ addr_q[15:8];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            phase_q <= sdcard_pkg::TX_IDLE;
            cnt_q   <= '0;
        end else begin
            case (phase_q)
                sdcard_pkg::TX_IDLE: begin
                    if (i_start) begin
                        phase_q <= sdcard_pkg::TX_TOKEN;
                    end
                end
                sdcard_pkg::TX_TOKEN: begin
                    phase_q <= sdcard_pkg::TX_DATA;
                    cnt_q   <= '0;
                end
                sdcard_pkg::TX_DATA: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == sdcard_pkg::BYTE_CNT_W'(sdcard_pkg::BLOCK_BYTES - 1)) begin
                        phase_q <= sdcard_pkg::TX_CRC_HI;
                    end
                end
                sdcard_pkg::TX_CRC_HI: phase_q <= sdcard_pkg::TX_CRC_LO;
                default:               phase_q <= sdcard_pkg::TX_IDLE;
            endcase
        end
    end

    // Byte address = block * 512 + index
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            addr_q <= 16'({i_block, {sdcard_pkg::BYTE_CNT_W{1'b0}}});
        end else if (phase_q == sdcard_pkg::TX_DATA) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    always_comb begin
        o_dat.last = (phase_q == sdcard_pkg::TX_CRC_LO);
        case (phase_q)
            sdcard_pkg::TX_TOKEN:  o_dat.data = sdcard_pkg::START_TOKEN;
            sdcard_pkg::TX_DATA:   o_dat.data = mem_byte;
            sdcard_pkg::TX_CRC_HI: o_dat.data = i_crc[15:8];
            sdcard_pkg::TX_CRC_LO: o_dat.data = i_crc[7:0];
            default:               o_dat.data = '0;
        endcase
    end

    assign o_dat_valid  = (phase_q != sdcard_pkg::TX_IDLE);
    assign o_active     = (phase_q != sdcard_pkg::TX_IDLE);
    assign o_crc_clear  = (phase_q == sdcard_pkg::TX_TOKEN);  // Seed before first data byte
    assign o_crc_update = (phase_q == sdcard_pkg::TX_DATA);
    assign o_crc_byte   = mem_byte;

    // The card never starts a second block on top of a running one
    a_no_restart: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_start |-> !o_active)
        else $error("block read started while streamer active");

endmodule

`default_nettype wire

// File: sdcard_cmd_fsm.sv
// Card state machine
// Decodes host commands, tracks identification states and OCR,
// builds R1/R3/R7 responses and launches single-block reads

`timescale 1ns/1ps
`default_nettype none

module sdcard_cmd_fsm (
    input  wire logic                 i_clk,
    input  wire logic                 i_nrst,
    input  wire logic                 i_spi_mode,
    input  wire logic                 i_cmd_valid,
    input  wire sdcard_pkg::cmd_req_t i_cmd,
    input  wire logic                 i_powered,
    input  wire logic                 i_delay_done,
    input  wire logic                 i_tx_active,
    output logic                      o_delay_start,
    output logic                      o_resp_valid,
    output sdcard_pkg::resp_t         o_resp,
    output logic                      o_busy,
    output logic                      o_read_start,
    output logic [31:0]               o_read_block
);

    sdcard_pkg::sd_state_t state_q;
    sdcard_pkg::sd_state_t nxt_state;
    sdcard_pkg::resp_kind_t nxt_kind;
    sdcard_pkg::resp_t     nxt_resp;
    logic                  ocr_hcs_q;
    logic [23:0]           ocr_window_q;
    logic                  busy_q;
    logic                  resp_valid_q;
    logic                  delay_start_q;
    logic                  read_pend_q;
    logic                  read_start_q;
    logic                  accept;
    logic                  nxt_ok;
    logic                  nxt_read;
    logic                  ocr_load;
    logic [31:0]           nxt_data;
    logic                  acmd_hcs;
    logic [23:0]           acmd_window;

    assign accept      = i_cmd_valid & ~busy_q;   // Commands during busy are dropped
    assign acmd_hcs    = i_cmd.arg[30] & sdcard_pkg::CARD_HCS;
    assign acmd_window = i_cmd.arg[23:0] & sdcard_pkg::CARD_VDD_WINDOW;

    always_comb begin
        nxt_state = state_q;
        nxt_ok    = 1'b0;
        nxt_kind  = sdcard_pkg::R1;
        nxt_data  = '0;
        nxt_read  = 1'b0;
        ocr_load  = 1'b0;
        case (state_q)
            sdcard_pkg::IDLE: begin
                case (i_cmd.idx)
                    sdcard_pkg::CMD_GO_IDLE: nxt_ok = 1'b1;
                    sdcard_pkg::CMD_APP:     nxt_ok = 1'b1;
                    sdcard_pkg::CMD_SEND_IF_COND: begin
                        nxt_ok         = 1'b1;
                        nxt_kind       = sdcard_pkg::R7;
                        nxt_data[11:8] = i_cmd.arg[11:8] & sdcard_pkg::CARD_VHS;
                        nxt_data[7:0]  = i_cmd.arg[7:0];   // Check pattern echo
                    end
                    sdcard_pkg::ACMD_SEND_OP_COND: begin
                        nxt_ok         = 1'b1;
                        nxt_kind       = sdcard_pkg::R3;
                        ocr_load       = 1'b1;
                        nxt_data[31]   = i_powered;        // Busy bit, low while powering up
                        nxt_data[30]   = acmd_hcs;
                        nxt_data[23:0] = acmd_window;
                        if (acmd_window == '0) begin
                            nxt_state = sdcard_pkg::INA;  // No usable voltage
                        end else if (!i_spi_mode && i_powered) begin
                            nxt_state = sdcard_pkg::READY;
                        end
                    end
                    sdcard_pkg::CMD_READ_OCR: begin
                        if (i_spi_mode) begin
                            nxt_ok         = 1'b1;
                            nxt_kind       = sdcard_pkg::R3;
                            nxt_data[30]   = ocr_hcs_q;
                            nxt_data[23:0] = ocr_window_q;
                        end
                    end
                    sdcard_pkg::CMD_READ_SINGLE: begin
                        if (i_spi_mode && !i_tx_active) begin
                            nxt_ok   = 1'b1;
                            nxt_read = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            sdcard_pkg::READY, sdcard_pkg::IDENT, sdcard_pkg::STBY: begin
                if (i_cmd.idx == sdcard_pkg::CMD_GO_IDLE) begin
                    nxt_ok    = 1'b1;
                    nxt_state = sdcard_pkg::IDLE;
                end else if (state_q == sdcard_pkg::READY &&
                             i_cmd.idx == sdcard_pkg::CMD_ALL_SEND_CID) begin
                    nxt_ok    = 1'b1;
                    nxt_state = sdcard_pkg::IDENT;
                end else if (state_q == sdcard_pkg::IDENT &&
                             i_cmd.idx == sdcard_pkg::CMD_SEND_RCA) begin
                    nxt_ok    = 1'b1;
                    nxt_state = sdcard_pkg::STBY;
                end
            end
            default: ;   // INA refuses everything
        endcase
        // Rejected commands answer all-ones with the illegal flag
        nxt_resp.data    = nxt_ok ? nxt_data : '1;
        nxt_resp.kind    = nxt_kind;
        nxt_resp.illegal = ~nxt_ok;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q       <= sdcard_pkg::IDLE;
            ocr_hcs_q     <= 1'b0;
            ocr_window_q  <= '0;
            busy_q        <= 1'b0;
            resp_valid_q  <= 1'b0;
            delay_start_q <= 1'b0;
            read_pend_q   <= 1'b0;
            read_start_q  <= 1'b0;
        end else begin
            delay_start_q <= accept;
            resp_valid_q  <= i_delay_done;
            read_start_q  <= i_delay_done & read_pend_q;  // Token follows the response
            if (accept) begin
                busy_q      <= 1'b1;
                state_q     <= nxt_state;
                read_pend_q <= nxt_read;
                if (ocr_load) begin
                    ocr_hcs_q    <= acmd_hcs;
                    ocr_window_q <= acmd_window;
                end
            end else begin
                if (resp_valid_q) begin
                    busy_q <= 1'b0;
                end
                if (i_delay_done) begin
                    read_pend_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_resp       <= nxt_resp;
            o_read_block <= i_cmd.arg;
        end
    end

    assign o_busy        = busy_q;
    assign o_resp_valid  = resp_valid_q;
    assign o_delay_start = delay_start_q;
    assign o_read_start  = read_start_q;

    // Timer expiry must land inside the command window
    a_resp_in_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_resp_valid |-> o_busy)
        else $error("response strobe outside busy window");

    a_no_cmd_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_cmd_valid |-> !o_busy)
        else $error("command strobed while card busy");

endmodule

`default_nettype wire

// File: sdcard_ctrl_top.sv
// SD card model top
// Joins the card state machine, timer, block streamer and data CRC

`timescale 1ns/1ps
`default_nettype none

module sdcard_ctrl_top (
    input  wire logic                 i_clk,
    input  wire logic                 i_nrst,
    input  wire logic                 i_spi_mode,
    input  wire logic                 i_cmd_valid,
    input  wire sdcard_pkg::cmd_req_t i_cmd,
    output logic                      o_resp_valid,
    output sdcard_pkg::resp_t         o_resp,
    output logic                      o_busy,
    output logic                      o_powered,
    output logic                      o_dat_valid,
    output sdcard_pkg::dat_t          o_dat
);

    logic        delay_start;
    logic        delay_done;
    logic        read_start;
    logic [31:0] read_block;
    logic        tx_active;
    logic        crc_clear;
    logic        crc_update;
    logic [7:0]  crc_byte;
    logic [15:0] crc;

    sdcard_cmd_fsm u_cmd_fsm (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_spi_mode    (i_spi_mode),
        .i_cmd_valid   (i_cmd_valid),
        .i_cmd         (i_cmd),
        .i_powered     (o_powered),
        .i_delay_done  (delay_done),
        .i_tx_active   (tx_active),
        .o_delay_start (delay_start),
        .o_resp_valid  (o_resp_valid),
        .o_resp        (o_resp),
        .o_busy        (o_busy),
        .o_read_start  (read_start),
        .o_read_block  (read_block)
    );

    sdcard_timer u_timer (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_start   (delay_start),
        .o_done    (delay_done),
        .o_powered (o_powered)
    );

    sdcard_data_tx u_data_tx (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_start      (read_start),
        .i_block      (read_block),
        .i_crc        (crc),
        .o_crc_clear  (crc_clear),
        .o_crc_update (crc_update),
        .o_crc_byte   (crc_byte),
        .o_active     (tx_active),
        .o_dat_valid  (o_dat_valid),
        .o_dat        (o_dat)
    );

    sdcard_crc16 u_crc16 (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_clear  (crc_clear),
        .i_update (crc_update),
        .i_byte   (crc_byte),
        .o_crc    (crc)
    );

endmodule

`default_nettype wire

// File: sdcard_checker.sv
// Scoreboard for the SD card model
// Predicts each response from the golden list and each read-data strobe
// from the card memory rule, and checks latency, busy and power-up timing

`timescale 1ns/1ps
`default_nettype none

module sdcard_checker (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire logic              i_cmd_valid,
    input  wire logic              i_busy,
    input  wire logic              i_powered,
    input  wire logic              i_resp_valid,
    input  wire sdcard_pkg::resp_t i_resp,
    input  wire logic              i_dat_valid,
    input  wire sdcard_pkg::dat_t  i_dat,
    output int                     o_mismatches,
    output int                     o_faults,
    output int                     o_resp_seen,
    output int                     o_blocks_seen
);

    logic [31:0] exp_data_q[$];
    logic [31:0] exp_arg_q[$];
    int          exp_kind_q[$];
    bit          exp_ill_q[$];
    bit          exp_blk_q[$];

    int          since = -1;   // Cycles since the command was taken
    bit          answered;
    int          resp_idx;
    int          pwr_cycles;
    bit          blk_on;
    int          blk_pos;
    int          blk_cmd;
    logic [31:0] blk_base;
    logic [15:0] blk_crc;

    // Card memory: A[7:0] ^ A[15:8]
    function automatic logic [7:0] card_byte(input logic [31:0] addr);
        return addr[7:0] ^ addr[15:8];
    endfunction

    function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] r;
        r = crc ^ {b, 8'h00};
        for (int k = 0; k < 8; k++) begin
            r = r[15] ? ((r << 1) ^ sdcard_pkg::CRC16_POLY) : (r << 1);
        end
        return r;
    endfunction

    initial begin
        int          fd;
        int          spi;
        int          idx;
        int          gap;
        int          kind;
        int          ill;
        int          blk;
        logic [31:0] arg;
        logic [31:0] data;
        string       line;
        fd = $fopen("sdcard_golden.txt", "r");
        if (fd == 0) begin
            $display("Error: checker could not open sdcard_golden.txt");
            o_faults++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "/" &&
                    $sscanf(line, "%d %d %h %d %h %d %d %d",
                            spi, idx, arg, gap, data, kind, ill, blk) == 8) begin
                    exp_data_q.push_back(data);
                    exp_arg_q.push_back(arg);
                    exp_kind_q.push_back(kind);
                    exp_ill_q.push_back(ill != 0);
                    exp_blk_q.push_back(blk != 0);
                end
            end
            $fclose(fd);
        end
    end

    task automatic check_response();
        if (resp_idx >= exp_data_q.size()) begin
            $display("Error at %0t: response %0d has no golden entry", $time, resp_idx);
            o_faults++;
        end else begin
            if (i_resp.data !== exp_data_q[resp_idx] ||
                int'(i_resp.kind) != exp_kind_q[resp_idx] ||
                i_resp.illegal !== exp_ill_q[resp_idx]) begin
                // Fields are data/kind/illegal
                $display("mismatch at %0t: response %0d is %h/%0d/%b, expected %h/%0d/%b",
                         $time, resp_idx, i_resp.data, i_resp.kind, i_resp.illegal,
                         exp_data_q[resp_idx], exp_kind_q[resp_idx], exp_ill_q[resp_idx]);
                o_mismatches++;
            end
            if (exp_blk_q[resp_idx]) begin   // Token due next cycle
                blk_on   = 1'b1;
                blk_pos  = 0;
                blk_cmd  = resp_idx;
                blk_crc  = '0;
                blk_base = exp_arg_q[resp_idx] << 9;
            end
        end
        resp_idx++;
        o_resp_seen++;
    endtask

    task automatic check_data();
        logic [7:0] exp_byte;
        logic       exp_last;
        exp_last = (blk_pos == sdcard_pkg::BLOCK_BYTES + 2);
        if (blk_pos == 0) begin
            exp_byte = sdcard_pkg::START_TOKEN;
        end else if (blk_pos <= sdcard_pkg::BLOCK_BYTES) begin
            exp_byte = card_byte(blk_base + 32'(blk_pos - 1));
            blk_crc  = crc_step(blk_crc, exp_byte);
        end else if (blk_pos == sdcard_pkg::BLOCK_BYTES + 1) begin
            exp_byte = blk_crc[15:8];
        end else begin
            exp_byte = blk_crc[7:0];
        end
        if (!i_dat_valid) begin
            $display("Error at %0t: block of command %0d stopped after %0d strobes",
                     $time, blk_cmd, blk_pos);
            o_faults++;
            blk_on = 1'b0;
        end else begin
            if (i_dat.data !== exp_byte || i_dat.last !== exp_last) begin
                $display("mismatch at %0t: block strobe %0d got %h last %b, expected %h last %b",
                         $time, blk_pos, i_dat.data, i_dat.last, exp_byte, exp_last);
                o_mismatches++;
            end
            blk_pos++;
            if (blk_pos == sdcard_pkg::BLOCK_BYTES + 3) begin
                blk_on = 1'b0;
                o_blocks_seen++;
            end
        end
    endtask

    always @(posedge i_clk) begin
        if (!i_nrst) begin
            since      = -1;
            pwr_cycles = 0;
            blk_on     = 1'b0;
        end else begin
            pwr_cycles++;
            if ((pwr_cycles == sdcard_pkg::POWERUP_CYCLES && i_powered) ||
                (pwr_cycles == sdcard_pkg::POWERUP_CYCLES + 1 && !i_powered)) begin
                $display("mismatch at %0t: o_powered is %b at cycle %0d after reset",
                         $time, i_powered, pwr_cycles);
                o_mismatches++;
            end
            if (blk_on) begin
                check_data();
            end else if (i_dat_valid) begin
                $display("mismatch at %0t: data strobe %h with no read pending", $time, i_dat.data);
                o_mismatches++;
            end
            if (since >= 0) begin
                since++;
                if (since <= sdcard_pkg::RESP_DELAY + 2 && !i_busy) begin
                    $display("mismatch at %0t: o_busy low %0d cycles into command", $time, since);
                    o_mismatches++;
                end
                if (since == sdcard_pkg::RESP_DELAY + 3) begin
                    if (i_busy) begin
                        $display("mismatch at %0t: o_busy still high after response", $time);
                        o_mismatches++;
                    end
                    since = -1;
                end else if (i_resp_valid && !answered) begin
                    if (since != sdcard_pkg::RESP_DELAY + 2) begin
                        $display("mismatch at %0t: response after %0d cycles, expected %0d",
                                 $time, since, sdcard_pkg::RESP_DELAY + 2);
                        o_mismatches++;
                    end
                    check_response();
                    answered = 1'b1;
                end else if (since == sdcard_pkg::RESP_DELAY + 2 && !answered) begin
                    $display("Error at %0t: no response to command %0d", $time, resp_idx);
                    o_faults++;
                    resp_idx++;
                    answered = 1'b1;
                end
            end else if (i_resp_valid) begin
                $display("mismatch at %0t: response strobe with no command pending", $time);
                o_mismatches++;
            end
            if (i_cmd_valid && !i_busy) begin
                since    = 0;
                answered = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_sdcard_ctrl_top.sv
// Testbench for the SD card model
// Replays the golden command list against the DUT, the checker module
// does all comparing and the top reports the result

`timescale 1ns/1ps
`default_nettype none

module tb_sdcard_ctrl_top;

    logic                 i_clk;
    logic                 i_nrst;
    logic                 i_spi_mode;
    logic                 i_cmd_valid;
    sdcard_pkg::cmd_req_t i_cmd;
    logic                 o_resp_valid;
    sdcard_pkg::resp_t    o_resp;
    logic                 o_busy;
    logic                 o_powered;
    logic                 o_dat_valid;
    sdcard_pkg::dat_t     o_dat;

    // Command list from the golden file
    bit          spi_q[$];
    logic [5:0]  idx_q[$];
    logic [31:0] arg_q[$];
    int          gap_q[$];
    bit          blk_q[$];

    int     n_blocks;
    int     cycle_cnt;
    int     cycle_limit;
    int     count_errs;
    int     mismatches;
    int     faults;
    int     resp_seen;
    int     blocks_seen;
    integer seed;
    bit     file_ok;

    sdcard_ctrl_top u_sdcard_ctrl_top (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_spi_mode   (i_spi_mode),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd        (i_cmd),
        .o_resp_valid (o_resp_valid),
        .o_resp       (o_resp),
        .o_busy       (o_busy),
        .o_powered    (o_powered),
        .o_dat_valid  (o_dat_valid),
        .o_dat        (o_dat)
    );

    sdcard_checker u_checker (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_cmd_valid   (i_cmd_valid),
        .i_busy        (o_busy),
        .i_powered     (o_powered),
        .i_resp_valid  (o_resp_valid),
        .i_resp        (o_resp),
        .i_dat_valid   (o_dat_valid),
        .i_dat         (o_dat),
        .o_mismatches  (mismatches),
        .o_faults      (faults),
        .o_resp_seen   (resp_seen),
        .o_blocks_seen (blocks_seen)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Run limit follows the length of the command list
    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Error: run stopped after %0d cycles, DUT never finished", cycle_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic load_commands(output bit ok);
        int          fd;
        int          cnt;
        int          spi;
        int          idx;
        int          gap;
        int          kind;
        int          ill;
        int          blk;
        logic [31:0] arg;
        logic [31:0] data;
        string       line;
        ok = 1'b0;
        fd = $fopen("sdcard_golden.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "/") begin
                    cnt = $sscanf(line, "%d %d %h %d %h %d %d %d",
                                  spi, idx, arg, gap, data, kind, ill, blk);
                    if (cnt == 8) begin
                        spi_q.push_back(spi != 0);
                        idx_q.push_back(6'(idx));
                        arg_q.push_back(arg);
                        gap_q.push_back(gap);
                        blk_q.push_back(blk != 0);
                        n_blocks    += (blk != 0);
                        cycle_limit += gap + sdcard_pkg::RESP_DELAY + 2;
                        cycle_limit += (blk != 0) ? sdcard_pkg::BLOCK_BYTES + 3 : 0;
                    end
                end
            end
            $fclose(fd);
            cycle_limit += 100;   // Reset and handshake slack
            ok = (spi_q.size() > 0);
        end
    endtask

    task automatic send_command(input int n);
        logic [31:0] arg;
        arg = arg_q[n];
        // CMD0 and CMD55 ignore their argument
        if (idx_q[n] == sdcard_pkg::CMD_GO_IDLE || idx_q[n] == sdcard_pkg::CMD_APP) begin
            arg[31:8] = 24'($random(seed));
        end
        repeat (gap_q[n]) @(negedge i_clk);
        @(negedge i_clk);
        i_spi_mode  = spi_q[n];
        i_cmd_valid = 1'b1;
        i_cmd.idx   = idx_q[n];
        i_cmd.arg   = arg;
        @(negedge i_clk);
        i_cmd_valid = 1'b0;
        while (!o_resp_valid) @(negedge i_clk);
        if (blk_q[n]) begin
            while (!(o_dat_valid && o_dat.last)) @(negedge i_clk);
        end
    endtask

    initial begin
        seed        = 6;
        i_nrst      = 1'b0;
        i_spi_mode  = 1'b0;
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
        load_commands(file_ok);
        if (!file_ok) begin
            $display("Error: golden file sdcard_golden.txt missing or empty");
            $display("Verification failed");
            $finish;
        end else begin
            repeat (3) @(negedge i_clk);
            i_nrst = 1'b1;
            for (int i = 0; i < spi_q.size(); i++) begin
                send_command(i);
            end
            repeat (4) @(negedge i_clk);   // Let the checker close its last window
            if (resp_seen != spi_q.size()) begin
                $display("Error: %0d responses checked for %0d commands", resp_seen, spi_q.size());
                count_errs++;
            end
            if (blocks_seen != n_blocks) begin
                $display("Error: %0d data blocks completed, %0d expected", blocks_seen, n_blocks);
                count_errs++;
            end
            $display("Summary: %0d mismatches, %0d other errors", mismatches, faults + count_errs);
            if (mismatches == 0 && faults == 0 && count_errs == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sdcard_golden.txt
// spi cmd arg(hex) gap exp_data(hex) kind illegal block
// kind 0=R1 1=R3 2=R7, block 1 means a 515-strobe read follows the response
0 0 00000000 0 00000000 0 0 0
0 8 000001aa 0 000001aa 2 0 0
0 55 00000000 0 00000000 0 0 0
0 41 40ff8000 0 40ff8000 1 0 0
0 55 00000000 30 00000000 0 0 0
0 41 40ff8000 0 c0ff8000 1 0 0
0 3 00000000 0 ffffffff 0 1 0
0 2 00000000 0 00000000 0 0 0
0 8 000001aa 0 ffffffff 0 1 0
0 3 00000000 0 00000000 0 0 0
0 0 00000000 0 00000000 0 0 0
0 17 00000000 0 ffffffff 0 1 0
0 58 00000000 0 ffffffff 0 1 0
0 8 000002aa 0 000000aa 2 0 0
1 41 00300000 0 80300000 1 0 0
1 58 00000000 0 00300000 1 0 0
1 41 40ff8000 0 c0ff8000 1 0 0
1 58 00000000 0 40ff8000 1 0 0
1 17 00000000 0 00000000 0 0 1
1 17 00000003 2 00000000 0 0 1
0 41 00007f00 0 80000000 1 0 0
0 0 00000000 0 ffffffff 0 1 0
0 8 000001aa 0 ffffffff 0 1 0
0 55 00000000 0 ffffffff 0 1 0

// File: sdcard_ctrl_top.f
sdcard_pkg.sv
sdcard_crc16.sv
sdcard_timer.sv
sdcard_data_tx.sv
sdcard_cmd_fsm.sv
sdcard_ctrl_top.sv
sdcard_checker.sv
tb_sdcard_ctrl_top.sv

// File: Bender.yml
package:
  name: sdcard_ctrl

sources:
  - sdcard_pkg.sv
  - sdcard_crc16.sv
  - sdcard_timer.sv
  - sdcard_data_tx.sv
  - sdcard_cmd_fsm.sv
  - sdcard_ctrl_top.sv
  - target: test
    files:
      - sdcard_checker.sv
      - tb_sdcard_ctrl_top.sv
